// File: hw/mips_defs.svh
// MIPS core definitions, widths, memory depths and the address map
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Data path and address width
`define MIPS_XLEN 32

// Register index width, 32 GPRs
`define MIPS_REG_AW 5

// Boot address, also the base of the program ROM
`define MIPS_RESET_PC 32'h0040_0000

// Memory depths in 32-bit words
`define MIPS_ROM_WORDS 64
`define MIPS_RAM_WORDS 64

// Data segment base and the GPIO data register just past the RAM
`define MIPS_RAM_BASE 32'h1001_0000
`define MIPS_GPIO_ADDR 32'h1001_0100

// Link register for jal
`define MIPS_RA_REG 31

`endif

// File: hw/mips_pkg.sv
// MIPS core package with the instruction encodings, FSM states and datapath select types
`include "mips_defs.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0]   word_t;
    typedef logic [`MIPS_REG_AW-1:0] reg_idx_t;

    // Primary opcode field, IR[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00, OP_J   = 6'h02, OP_JAL = 6'h03,
        OP_BEQ   = 6'h04, OP_BNE = 6'h05, OP_ADDI = 6'h08,
        OP_ORI   = 6'h0d, OP_LW  = 6'h23, OP_SW  = 6'h2b
    } opcode_e;

    // R-type function field, IR[5:0]
    typedef enum logic [5:0] {
        F_SLL = 6'h00, F_SRL = 6'h02, F_JR  = 6'h08, F_ADD = 6'h20,
        F_SUB = 6'h22, F_AND = 6'h24, F_OR  = 6'h25, F_SLT = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_SRL
    } alu_op_e;

    typedef enum logic [3:0] {
        S_FETCH, S_DECODE, S_EXEC, S_MEM_ADDR, S_MEM_READ,
        S_MEM_WRITE, S_WB_ALU, S_WB_MEM, S_BRANCH, S_JUMP
    } ctrl_state_e;

    typedef enum logic       {SRC_A_PC, SRC_A_REG} src_a_e;
    typedef enum logic [1:0] {SRC_B_REG, SRC_B_FOUR, SRC_B_IMM, SRC_B_IMM_SH2} src_b_e;
    typedef enum logic [1:0] {PC_SRC_ALU, PC_SRC_ALUOUT, PC_SRC_JUMP, PC_SRC_REG_A} pc_src_e;
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} reg_dst_e;
    typedef enum logic [1:0] {WB_ALUOUT, WB_MDR, WB_PC} wb_src_e;

endpackage

// File: hw/mips_alu.sv
// MIPS integer ALU, add, sub, logic, signed set-less-than and shifts by shamt
`timescale 1ns/1ns

module mips_alu
    import mips_pkg::*;
(
    input  word_t      a,
    input  word_t      b,
    input  alu_op_e    op,
    input  logic [4:0] shamt,
    output word_t      y,
    output logic       zero
);

    word_t diff;

    assign diff = a - b;    // Shared by sub and the branch compare

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = diff;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_SLT: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLL: y = b << shamt;   // Shift source is rt
            ALU_SRL: y = b >> shamt;   // Logical, zero fill
            default: y = a + b;
        endcase
    end

    assign zero = (y == '0);

endmodule

// File: hw/mips_regfile.sv
// MIPS register file, 32 GPRs with two async read ports and one write port, $0 stays zero
`timescale 1ns/1ns

module mips_regfile
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t ra1,
    input  reg_idx_t ra2,
    input  reg_idx_t wa,
    input  word_t    wd,
    input  logic     we,
    output word_t    rd1,
    output word_t    rd2
);

    word_t regs [2**$bits(reg_idx_t)];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**$bits(reg_idx_t); i++) regs[i] <= '0;
        end else if (we && (wa != '0)) begin  // Writes to $0 are dropped
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// File: hw/mips_datapath.sv
// Multicycle MIPS datapath, PC and holding registers, operand muxes, ALU and register file
`timescale 1ns/1ns
`include "mips_defs.svh"

module mips_datapath
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     pc_write,
    input  logic     ir_write,
    input  logic     mdr_write,
    input  logic     ab_write,
    input  logic     aluout_write,
    input  logic     reg_write,
    input  logic     addr_from_alu,
    input  src_a_e   src_a_sel,
    input  src_b_e   src_b_sel,
    input  pc_src_e  pc_src_sel,
    input  reg_dst_e reg_dst_sel,
    input  wb_src_e  wb_src_sel,
    input  alu_op_e  alu_op,
    output logic     zero,
    output opcode_e  opcode,
    output funct_e   funct,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    input  word_t    mem_rdata      // Same-cycle read data
);

    word_t    pc, ir, mdr, a, b, alu_out;
    word_t    pc_next;
    word_t    rd1, rd2;
    word_t    src_a, src_b, alu_y;
    word_t    imm_ext, imm_sh2, jump_target, wb_data;
    reg_idx_t rs, rt, rd, wa;
    logic [4:0]  shamt;
    logic [15:0] imm16;

    // Instruction fields
    assign opcode = opcode_e'(ir[31:26]);
    assign funct  = funct_e'(ir[5:0]);
    assign rs     = ir[25:21];
    assign rt     = ir[20:16];
    assign rd     = ir[15:11];
    assign shamt  = ir[10:6];
    assign imm16  = ir[15:0];

    // ori takes a zero-extended immediate, everything else sign-extends
    assign imm_ext     = (opcode == OP_ORI) ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
    assign imm_sh2     = {imm_ext[29:0], 2'b00};          // Branch word offset
    assign jump_target = {pc[31:28], ir[25:0], 2'b00};    // Region of PC + 4

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `MIPS_RESET_PC;
            ir <= '0;
        end else begin
            if (pc_write) pc <= pc_next;
            if (ir_write) ir <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (mdr_write)    mdr     <= mem_rdata;
        if (aluout_write) alu_out <= alu_y;
        if (ab_write) begin
            a <= rd1;
            b <= rd2;
        end
    end

    assign src_a = (src_a_sel == SRC_A_REG) ? a : pc;

    always_comb begin
        case (src_b_sel)
            SRC_B_REG:  src_b = b;
            SRC_B_FOUR: src_b = 32'd4;
            SRC_B_IMM:  src_b = imm_ext;
            default:    src_b = imm_sh2;
        endcase
    end

    always_comb begin
        case (pc_src_sel)
            PC_SRC_ALU:    pc_next = alu_y;
            PC_SRC_ALUOUT: pc_next = alu_out;   // Branch target from DECODE
            PC_SRC_JUMP:   pc_next = jump_target;
            default:       pc_next = a;         // jr
        endcase
    end

    always_comb begin
        case (reg_dst_sel)
            DST_RD:  wa = rd;
            DST_RA:  wa = reg_idx_t'(`MIPS_RA_REG);
            default: wa = rt;
        endcase
        case (wb_src_sel)
            WB_MDR:  wb_data = mdr;
            WB_PC:   wb_data = pc;              // Return address for jal
            default: wb_data = alu_out;
        endcase
    end

    assign mem_addr  = addr_from_alu ? alu_out : pc;
    assign mem_wdata = b;

    mips_regfile i_regfile (
        .clk, .rst,
        .ra1 (rs),
        .ra2 (rt),
        .wa  (wa),
        .wd  (wb_data),
        .we  (reg_write),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    mips_alu i_alu (
        .a (src_a), .b (src_b), .op (alu_op), .shamt (shamt),
        .y (alu_y), .zero (zero)
    );

endmodule

// File: hw/mips_control.sv
// Multicycle MIPS control FSM, steps each instruction and drives datapath enables and selects
`timescale 1ns/1ns

module mips_control
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  opcode_e  opcode,
    input  funct_e   funct,
    input  logic     zero,          // ALU result was zero, used for branches
    output logic     pc_write,
    output logic     ir_write,
    output logic     mdr_write,
    output logic     ab_write,
    output logic     aluout_write,
    output logic     reg_write,
    output logic     mem_write,
    output logic     addr_from_alu, // Memory address from ALU out, else PC
    output src_a_e   src_a_sel,
    output src_b_e   src_b_sel,
    output pc_src_e  pc_src_sel,
    output reg_dst_e reg_dst_sel,
    output wb_src_e  wb_src_sel,
    output alu_op_e  alu_op
);

    ctrl_state_e state, state_next;
    alu_op_e     funct_op;          // ALU operation for the R-type funct
    logic        funct_ok;          // Funct is an ALU R-type we execute
    logic        branch_taken;

    // R-type funct decode, jr is steered by DECODE and never reaches EXEC
    always_comb begin
        funct_ok = 1'b1;
        case (funct)
            F_ADD:   funct_op = ALU_ADD;
            F_SUB:   funct_op = ALU_SUB;
            F_AND:   funct_op = ALU_AND;
            F_OR:    funct_op = ALU_OR;
            F_SLT:   funct_op = ALU_SLT;
            F_SLL:   funct_op = ALU_SLL;
            F_SRL:   funct_op = ALU_SRL;
            default: begin
                funct_op = ALU_ADD;
                funct_ok = 1'b0;
            end
        endcase
    end

    assign branch_taken = (opcode == OP_BEQ) ? zero : !zero; // bne on non-zero

    always_ff @(posedge clk) begin
        if (rst) state <= S_FETCH;
        else     state <= state_next;
    end

    // Next state
    always_comb begin
        state_next = S_FETCH;
        case (state)
            S_FETCH:  state_next = S_DECODE;
            S_DECODE: begin
                case (opcode)
                    OP_RTYPE: begin
                        if (funct == F_JR) state_next = S_JUMP;
                        else if (funct_ok) state_next = S_EXEC;
                    end
                    OP_ADDI, OP_ORI: state_next = S_EXEC;
                    OP_LW, OP_SW:    state_next = S_MEM_ADDR;
                    OP_BEQ, OP_BNE:  state_next = S_BRANCH;
                    OP_J, OP_JAL:    state_next = S_JUMP;
                    default:         state_next = S_FETCH; // Unknown opcode, skip it
                endcase
            end
            S_EXEC:     state_next = S_WB_ALU;
            S_MEM_ADDR: state_next = (opcode == OP_LW) ? S_MEM_READ : S_MEM_WRITE;
            S_MEM_READ: state_next = S_WB_MEM;
            default:    state_next = S_FETCH; // Writeback, store, branch and jump end here
        endcase
    end

    // State outputs
    always_comb begin
        pc_write      = 1'b0;
        ir_write      = 1'b0;
        mdr_write     = 1'b0;
        ab_write      = 1'b0;
        aluout_write  = 1'b0;
        reg_write     = 1'b0;
        mem_write     = 1'b0;
        addr_from_alu = 1'b0;
        src_a_sel     = SRC_A_PC;
        src_b_sel     = SRC_B_FOUR;
        pc_src_sel    = PC_SRC_ALU;
        reg_dst_sel   = DST_RT;
        wb_src_sel    = WB_ALUOUT;
        alu_op        = ALU_ADD;
        case (state)
            S_FETCH: begin           // IR <- mem[PC], PC <- PC + 4
                ir_write = 1'b1;
                pc_write = 1'b1;
            end
            S_DECODE: begin          // Operands in, branch target into ALU out
                ab_write     = 1'b1;
                aluout_write = 1'b1;
                src_b_sel    = SRC_B_IMM_SH2;
            end
            S_EXEC: begin
                aluout_write = 1'b1;
                src_a_sel    = SRC_A_REG;
                if (opcode == OP_RTYPE) begin
                    src_b_sel = SRC_B_REG;
                    alu_op    = funct_op;
                end else begin
                    src_b_sel = SRC_B_IMM;
                    alu_op    = (opcode == OP_ORI) ? ALU_OR : ALU_ADD;
                end
            end
            S_MEM_ADDR: begin        // Effective address = rs + offset
                aluout_write = 1'b1;
                src_a_sel    = SRC_A_REG;
                src_b_sel    = SRC_B_IMM;
            end
            S_MEM_READ: begin
                addr_from_alu = 1'b1;
                mdr_write     = 1'b1;
            end
            S_MEM_WRITE: begin
                addr_from_alu = 1'b1;
                mem_write     = 1'b1;
            end
            S_WB_ALU: begin
                reg_write   = 1'b1;
                reg_dst_sel = (opcode == OP_RTYPE) ? DST_RD : DST_RT;
            end
            S_WB_MEM: begin
                reg_write  = 1'b1;
                wb_src_sel = WB_MDR;
            end
            S_BRANCH: begin          // Compare rs and rt, target already in ALU out
                src_a_sel  = SRC_A_REG;
                src_b_sel  = SRC_B_REG;
                alu_op     = ALU_SUB;
                pc_src_sel = PC_SRC_ALUOUT;
                pc_write   = branch_taken;
            end
            S_JUMP: begin
                pc_write    = 1'b1;
                pc_src_sel  = (opcode == OP_RTYPE) ? PC_SRC_REG_A : PC_SRC_JUMP;
                reg_write   = (opcode == OP_JAL);  // Link, PC already holds PC + 4
                reg_dst_sel = DST_RA;
                wb_src_sel  = WB_PC;
            end
            default: ;
        endcase
    end

endmodule

// File: hw/mips_mem_system.sv
// MIPS memory system, program ROM with reset-time load, data RAM and GPIO store register
`timescale 1ns/1ns
`include "mips_defs.svh"

module mips_mem_system
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  word_t      addr,
    input  word_t      wdata,
    input  logic       we,
    output word_t      rdata,
    input  logic       prog_we,
    input  logic [$clog2(`MIPS_ROM_WORDS)-1:0] prog_addr,
    input  word_t      prog_data,
    output logic [7:0] gpio_data,
    output logic       gpio_strobe   // One cycle per GPIO store
);

    localparam int ROM_AW = $clog2(`MIPS_ROM_WORDS);
    localparam int RAM_AW = $clog2(`MIPS_RAM_WORDS);

    word_t rom [`MIPS_ROM_WORDS];
    word_t ram [`MIPS_RAM_WORDS];
    word_t rom_off, ram_off;
    logic  rom_hit, ram_hit, gpio_hit;

    // Offsets wrap below each base, so one compare covers the window
    assign rom_off  = addr - `MIPS_RESET_PC;
    assign ram_off  = addr - `MIPS_RAM_BASE;
    assign rom_hit  = rom_off < (`MIPS_ROM_WORDS * 4);
    assign ram_hit  = ram_off < (`MIPS_RAM_WORDS * 4);
    assign gpio_hit = (addr == `MIPS_GPIO_ADDR);

    // Loader owns the ROM while the core sits in reset
    always_ff @(posedge clk) begin
        if (rst && prog_we) rom[prog_addr] <= prog_data;
    end

    always_ff @(posedge clk) begin
        if (we && ram_hit) ram[ram_off[RAM_AW+1:2]] <= wdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_data   <= '0;
            gpio_strobe <= 1'b0;
        end else begin
            gpio_strobe <= we && gpio_hit;
            if (we && gpio_hit) gpio_data <= wdata[7:0];  // Low byte only
        end
    end

    // Unmapped space reads as zero
    always_comb begin
        if (rom_hit)      rdata = rom[rom_off[ROM_AW+1:2]];
        else if (ram_hit) rdata = ram[ram_off[RAM_AW+1:2]];
        else              rdata = '0;
    end

endmodule

// File: hw/mips_multicycle.sv
// Multicycle MIPS-32 core top, joins control, datapath and the memory system
`timescale 1ns/1ns

module mips_multicycle
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       prog_we,      // ROM load strobe, honored only in reset
    input  logic [5:0] prog_addr,    // ROM word index
    input  word_t      prog_data,
    output logic [7:0] gpio_data,
    output logic       gpio_strobe
);

    logic        pc_write, ir_write, mdr_write, ab_write, aluout_write, reg_write;
    logic        mem_write;
    logic        addr_from_alu;
    src_a_e      src_a_sel;
    src_b_e      src_b_sel;
    pc_src_e     pc_src_sel;
    reg_dst_e    reg_dst_sel;
    wb_src_e     wb_src_sel;
    alu_op_e     alu_op;
    opcode_e     opcode;
    funct_e      funct;
    logic        zero;
    word_t       mem_addr, mem_wdata, mem_rdata;

    mips_control i_control (
        .clk, .rst, .opcode, .funct, .zero,
        .pc_write, .ir_write, .mdr_write, .ab_write, .aluout_write, .reg_write,
        .mem_write, .addr_from_alu,
        .src_a_sel, .src_b_sel, .pc_src_sel, .reg_dst_sel, .wb_src_sel, .alu_op
    );

    mips_datapath i_datapath (
        .clk, .rst,
        .pc_write, .ir_write, .mdr_write, .ab_write, .aluout_write, .reg_write,
        .addr_from_alu,
        .src_a_sel, .src_b_sel, .pc_src_sel, .reg_dst_sel, .wb_src_sel, .alu_op,
        .zero, .opcode, .funct,
        .mem_addr, .mem_wdata, .mem_rdata
    );

    mips_mem_system i_mem (
        .clk, .rst,
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .we     (mem_write),
        .rdata  (mem_rdata),
        .prog_we, .prog_addr, .prog_data,
        .gpio_data, .gpio_strobe
    );

endmodule

// File: dv/tb_mips.sv
// Directed testbench for the multicycle MIPS core that runs small programs and checks GPIO stores
`timescale 1ns/1ns
`include "mips_defs.svh"

module tb_mips;

    localparam int CLK_NS = 4;
    localparam int TOTAL_INSTRS = 140;   // Dynamic instruction count of all six programs rounded up
    localparam int WATCHDOG_NS = 2 * (TOTAL_INSTRS * 5 + 6 * 64) * CLK_NS; // Reset and load too

    // MIPS opcode and funct encodings
    localparam logic [5:0] OP_J = 6'h02, OP_JAL = 6'h03, OP_BEQ = 6'h04, OP_BNE = 6'h05;
    localparam logic [5:0] OP_ADDI = 6'h08, OP_ORI = 6'h0d, OP_LW = 6'h23, OP_SW = 6'h2b;
    localparam logic [5:0] F_SLL = 6'h00, F_SRL = 6'h02, F_JR = 6'h08, F_ADD = 6'h20;
    localparam logic [5:0] F_SUB = 6'h22, F_AND = 6'h24, F_OR = 6'h25, F_SLT = 6'h2a;

    // Register numbers where BASE holds the RAM base through every program
    localparam logic [4:0] R_ZERO = 5'd0, T0 = 5'd8, T1 = 5'd9, T2 = 5'd10, T3 = 5'd11;
    localparam logic [4:0] T4 = 5'd12, T5 = 5'd13, T6 = 5'd14, T7 = 5'd15;
    localparam logic [4:0] BASE = 5'd17, RA = `MIPS_RA_REG;

    logic        clk, rst, prog_we, gpio_strobe;
    logic [5:0]  prog_addr;
    logic [31:0] prog_data;
    logic [7:0]  gpio_data;
    logic [31:0] prog[$];     // Program under construction
    logic [31:0] exp_q[$];    // Expected GPIO values of which the low byte is compared
    logic [7:0]  seen[$];     // GPIO values seen with a strobe
    integer      seed;

    mips_multicycle i_dut (
        .clk, .rst, .prog_we, .prog_addr, .prog_data, .gpio_data, .gpio_strobe
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (gpio_strobe) seen.push_back(gpio_data);   // Registered output is stable mid-cycle
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, an expected GPIO store never arrived", WATCHDOG_NS);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [31:0] r_format(input logic [5:0] fn, input logic [4:0] rd, rs, rt,
                                             input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_format(input logic [5:0] op, input logic [4:0] rt, rs,
                                             input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_format(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};        // Word address within the 256 MB region
    endfunction

    function automatic logic [31:0] addr_of(input int idx);
        return `MIPS_RESET_PC + 32'(idx * 4);
    endfunction

    // Branch offset counts words from the instruction after the branch
    function automatic logic [15:0] offset_to(input int from_idx, input int to_idx);
        int diff;
        diff = to_idx - (from_idx + 1);
        return diff[15:0];
    endfunction

    function automatic logic [31:0] sign_extend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic compare(input logic [7:0] got, input logic [7:0] want, input string what);
        if (got !== want) begin
            $display("ERROR: time %0t ns: %s, got 0x%02h, expected 0x%02h", $time, what, got, want);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Fresh program that opens by building the RAM base in BASE
    task automatic start_program();
        logic [31:0] base_addr;
        base_addr = `MIPS_RAM_BASE;
        prog.delete();
        exp_q.delete();
        prog.push_back(i_format(OP_ORI, BASE, R_ZERO, base_addr[31:16]));
        prog.push_back(r_format(F_SLL, BASE, R_ZERO, BASE, 5'd16));
        prog.push_back(i_format(OP_ORI, BASE, BASE, base_addr[15:0]));
    endtask

    task automatic to_gpio(input logic [4:0] rt);
        logic [31:0] off;
        off = `MIPS_GPIO_ADDR - `MIPS_RAM_BASE;   // GPIO sits just past the RAM
        prog.push_back(i_format(OP_SW, rt, BASE, off[15:0]));
    endtask

    task automatic self_loop();
        prog.push_back(j_format(OP_J, addr_of(prog.size())));
    endtask

    // One instruction writing T2 and a store of T2 to GPIO
    task automatic store_result(input logic [31:0] instr, input logic [31:0] want);
        prog.push_back(instr);
        to_gpio(T2);
        exp_q.push_back(want);
    endtask

    // Holds reset at least 10 cycles while it writes the ROM and checks that GPIO stays quiet
    task automatic load_rom();
        int n;
        n = (prog.size() > 10) ? prog.size() : 10;
        next_edge();
        rst = 1'b1;
        for (int i = 0; i < n; i++) begin
            prog_we = (i < prog.size());
            prog_addr = i[5:0];
            prog_data = (i < prog.size()) ? prog[i] : 32'h0;
            next_edge();
            compare(gpio_data, 8'h00, "gpio_data during reset");
            compare({7'b0, gpio_strobe}, 8'h00, "gpio_strobe during reset");
        end
        prog_we = 1'b0;
        seen.delete();
        rst = 1'b0;                       // First FETCH follows the next edge
    endtask

    task automatic wait_strobes(input int n);
        while (seen.size() < n) @(posedge clk);
    endtask

    task automatic run_program(input string name);
        self_loop();
        load_rom();
        wait_strobes(exp_q.size());
        foreach (exp_q[i]) compare(seen[i], exp_q[i][7:0], $sformatf("%s, store %0d", name, i));
        $display("%s: %0d GPIO values checked", name, exp_q.size());
    endtask

    task automatic reset_quiet();
        start_program();
        prog.push_back(i_format(OP_ADDI, T0, R_ZERO, 16'h005a));
        prog.push_back(i_format(OP_ORI, T1, R_ZERO, 16'h0011));
        prog.push_back(i_format(OP_SW, T1, BASE, 16'h0000));   // RAM store without a strobe
        to_gpio(T0);
        self_loop();
        load_rom();
        while (gpio_strobe == 1'b0) begin
            compare(gpio_data, 8'h00, "gpio_data before the first GPIO store");
            @(negedge clk);
        end
        wait_strobes(1);
        compare(seen[0], 8'h5a, "first GPIO store");
        $display("reset: GPIO quiet until the first store");
    endtask

    task automatic alu_ops();
        logic [31:0] a, b;
        a = 32'h0000_00c3;                // ori zero-extends
        b = sign_extend(16'hffa9);        // addi sign-extends
        start_program();
        prog.push_back(i_format(OP_ORI, T0, R_ZERO, 16'h00c3));
        prog.push_back(i_format(OP_ADDI, T1, R_ZERO, 16'hffa9));
        store_result(r_format(F_ADD, T2, T0, T1, 5'd0), a + b);
        store_result(r_format(F_SUB, T2, T0, T1, 5'd0), a - b);
        store_result(r_format(F_SUB, T2, T1, T0, 5'd0), b - a);
        store_result(r_format(F_AND, T2, T0, T1, 5'd0), a & b);
        store_result(r_format(F_OR, T2, T0, T1, 5'd0), a | b);
        store_result(r_format(F_SLT, T2, T1, T0, 5'd0), 32'd1);   // -87 below 195 when signed
        store_result(r_format(F_SLT, T2, T0, T1, 5'd0), 32'd0);
        store_result(i_format(OP_ADDI, T2, T0, 16'h7f21), a + sign_extend(16'h7f21));
        store_result(i_format(OP_ADDI, T2, T0, 16'hff3a), a + sign_extend(16'hff3a));
        store_result(i_format(OP_ORI, T2, T1, 16'h8046), b | 32'h0000_8046);
        prog.push_back(i_format(OP_ORI, T3, R_ZERO, 16'h8000));
        store_result(r_format(F_SRL, T2, R_ZERO, T3, 5'd12), 32'h0000_8000 >> 12); // Upper half zero
        run_program("alu");
    endtask

    task automatic shift_ops();
        logic [31:0] v;
        v = 32'h0000_b5c3;
        start_program();
        prog.push_back(i_format(OP_ORI, T0, R_ZERO, v[15:0]));
        store_result(r_format(F_SLL, T2, R_ZERO, T0, 5'd1), v << 1);
        store_result(r_format(F_SLL, T2, R_ZERO, T0, 5'd3), v << 3);
        store_result(r_format(F_SRL, T2, R_ZERO, T0, 5'd4), v >> 4);
        store_result(r_format(F_SRL, T2, R_ZERO, T0, 5'd8), v >> 8);
        store_result(r_format(F_SRL, T2, R_ZERO, T0, 5'd13), v >> 13);
        prog.push_back(r_format(F_SLL, T3, R_ZERO, T0, 5'd31));
        store_result(r_format(F_SRL, T2, R_ZERO, T3, 5'd31), (v << 31) >> 31);
        prog.push_back(i_format(OP_ADDI, R_ZERO, T0, 16'h0055));  // Writes to $0 are lost
        prog.push_back(r_format(F_ADD, R_ZERO, T0, T0, 5'd0));
        store_result(r_format(F_OR, T2, R_ZERO, R_ZERO, 5'd0), 32'h0);
        to_gpio(R_ZERO);
        exp_q.push_back(32'h0);
        store_result(r_format(F_ADD, T2, R_ZERO, T0, 5'd0), v);
        run_program("shift");
    endtask

    task automatic ram_round_trip();
        logic [31:0] w0, w1, w2, w3;
        w0 = 32'h0000_1234;
        w1 = 32'h0000_00ab;
        w2 = sign_extend(16'hfff0);
        w3 = 32'h0000_4321;
        start_program();
        prog.push_back(i_format(OP_ORI, T0, R_ZERO, w0[15:0]));
        prog.push_back(i_format(OP_ORI, T1, R_ZERO, w1[15:0]));
        prog.push_back(i_format(OP_ADDI, T2, R_ZERO, w2[15:0]));
        prog.push_back(i_format(OP_ORI, T3, R_ZERO, w3[15:0]));
        prog.push_back(i_format(OP_SW, T0, BASE, 16'h0000));
        prog.push_back(i_format(OP_SW, T1, BASE, 16'h0004));
        prog.push_back(i_format(OP_SW, T2, BASE, 16'h0008));
        prog.push_back(i_format(OP_SW, T3, BASE, 16'h00fc));   // Last RAM word
        prog.push_back(i_format(OP_LW, T4, BASE, 16'h00fc));   // Reload in another order
        prog.push_back(i_format(OP_LW, T5, BASE, 16'h0000));
        prog.push_back(i_format(OP_LW, T6, BASE, 16'h0008));
        prog.push_back(i_format(OP_LW, T7, BASE, 16'h0004));
        to_gpio(T4);
        exp_q.push_back(w3);
        prog.push_back(r_format(F_ADD, T2, T4, T5, 5'd0));
        prog.push_back(r_format(F_ADD, T2, T2, T6, 5'd0));
        store_result(r_format(F_ADD, T2, T2, T7, 5'd0), w0 + w1 + w2 + w3);
        run_program("ram");
    endtask

    task automatic control_flow();
        int loop_idx, jal_idx;
        start_program();
        prog.push_back(i_format(OP_ADDI, T0, R_ZERO, 16'd5));  // Countdown from five
        loop_idx = prog.size();
        to_gpio(T0);
        prog.push_back(i_format(OP_ADDI, T0, T0, 16'hffff));
        prog.push_back(i_format(OP_BNE, R_ZERO, T0, offset_to(prog.size(), loop_idx)));
        for (int n = 5; n >= 1; n--) exp_q.push_back(32'(n));
        prog.push_back(i_format(OP_ADDI, T1, R_ZERO, 16'd7));
        prog.push_back(i_format(OP_ADDI, T2, R_ZERO, 16'd7));
        prog.push_back(i_format(OP_ORI, T3, R_ZERO, 16'h00ee)); // Marker that must never show
        prog.push_back(i_format(OP_BEQ, T2, T1, 16'd1));        // Taken
        to_gpio(T3);
        prog.push_back(i_format(OP_BEQ, R_ZERO, T1, 16'd1));    // Not taken
        to_gpio(T1);
        exp_q.push_back(32'd7);
        prog.push_back(i_format(OP_BNE, R_ZERO, T1, 16'd1));    // Taken
        to_gpio(T3);
        prog.push_back(i_format(OP_BNE, T2, T1, 16'd1));        // Not taken
        prog.push_back(i_format(OP_ORI, T4, R_ZERO, 16'h003c));
        to_gpio(T4);
        exp_q.push_back(32'h3c);
        prog.push_back(i_format(OP_ORI, T5, R_ZERO, 16'h00a1));
        prog.push_back(i_format(OP_ORI, T6, R_ZERO, 16'h00b2));
        jal_idx = prog.size();
        prog.push_back(j_format(OP_JAL, addr_of(jal_idx + 3)));
        to_gpio(T6);                      // Return lands here
        self_loop();
        to_gpio(T5);                      // Routine body
        to_gpio(RA);
        prog.push_back(r_format(F_JR, R_ZERO, RA, R_ZERO, 5'd0));
        exp_q.push_back(32'h a1);
        exp_q.push_back(addr_of(jal_idx + 1));                  // Link is PC + 4
        exp_q.push_back(32'h b2);
        run_program("control");
    endtask

    task automatic random_addi();
        logic [31:0] rnd, sum;
        logic [15:0] imm;
        sum = 32'h0;
        start_program();
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            imm = rnd[15:0];
            sum = sum + sign_extend(imm);
            prog.push_back(i_format(OP_ADDI, T0, T0, imm));  // T0 starts cleared by reset
            to_gpio(T0);
            exp_q.push_back(sum);
        end
        run_program("random addi");
    endtask

    initial begin
        rst = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        seed = 32'hc5959b09;
        reset_quiet();
        alu_ops();
        shift_ops();
        ram_round_trip();
        control_flow();
        random_addi();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: flist.f
+incdir+hw
hw/mips_pkg.sv
hw/mips_alu.sv
hw/mips_regfile.sv
hw/mips_datapath.sv
hw/mips_control.sv
hw/mips_mem_system.sv
hw/mips_multicycle.sv
dv/tb_mips.sv

// File: Makefile
# Verilator build and run for the multicycle MIPS core testbench

SRCS := $(filter-out +%,$(shell cat flist.f))

.PHONY: all run clean

all: run

obj_dir/Vtb_mips: flist.f $(SRCS) hw/mips_defs.svh
	verilator --binary -f flist.f --top-module tb_mips

run: obj_dir/Vtb_mips
	./obj_dir/Vtb_mips | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null

clean:
	rm -rf obj_dir
